// ==== project.f ====
src/fp_sum_pkg.sv
src/fp32_adder.sv
src/operand_collector.sv
src/adder_tree.sv
src/fp_sum32.sv
tb/fp_sum_checker.sv
tb/tb_fp_sum32.sv

// ==== run.sh ====
#!/bin/sh
# build and run the fp_sum32 testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_fp_sum32 -Mdir obj_dir -f project.f
./obj_dir/Vtb_fp_sum32 | tee sim.log

if grep -q 'All tests passed!' sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

// ==== tb/tb_fp_sum32.sv ====
module tb_fp_sum32
	import fp_sum_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int          NUM_GROUPS     = 34;
	localparam int          TIMEOUT_CYCLES = NUM_GROUPS * 64 + 200;
	localparam logic [31:0] LCG_SEED       = 32'h4cd821d7;

	logic  clk;
	logic  rst_n;
	logic  i_valid;
	fp32_t i_data;
	logic  o_valid;
	fp32_t o_sum;

	logic  known_valid;   // group below has a sum fixed by hand
	fp32_t known_sum;
	int    checks;
	int    errors;
	int    pending;
	int    cycles = 0;

	logic [31:0] seed;
	fp32_t       grp [NUM_INPUTS];   // next group to send

	fp_sum32 i_fp_sum32 (
		.clk     (clk),
		.rst_n   (rst_n),
		.i_valid (i_valid),
		.i_data  (i_data),
		.o_valid (o_valid),
		.o_sum   (o_sum)
	);

	fp_sum_checker i_checker (
		.clk           (clk),
		.rst_n         (rst_n),
		.i_valid       (i_valid),
		.i_data        (i_data),
		.i_sum_valid   (o_valid),
		.i_sum         (o_sum),
		.i_known_valid (known_valid),
		.i_known_sum   (known_sum),
		.o_checks      (checks),
		.o_errors      (errors),
		.o_pending     (pending)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles with %0d results still pending", cycles, pending);
			$display("Test failures found");
			$finish;
		end
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic int rand_below(input int n);
		seed = lcg_next(seed);
		return int'(seed[31:16]) % n;
	endfunction

	// normal float with random sign and mantissa
	function automatic fp32_t random_float(input int exp_lo, input int exp_hi);
		logic        sgn;
		int          ex;
		logic [22:0] man;
		seed = lcg_next(seed);
		sgn  = seed[31];
		ex   = exp_lo + rand_below(exp_hi - exp_lo + 1);
		seed = lcg_next(seed);
		man  = seed[31:9];
		return {sgn, 8'(ex), man};
	endfunction

	// small positive integer to its binary32 encoding
	function automatic fp32_t int_to_fp(input int n);
		int          p;
		logic [31:0] u;
		p = 0;
		u = n;
		for (int i = 0; i < 32; i++)
			if (u[i]) p = i;
		return {1'b0, 8'(127 + p), 23'(u << (23 - p))};
	endfunction

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(negedge clk);
			i_valid = 1'b0;
		end
	endtask

	// i_valid stays high after the last word so the caller decides on idle
	task automatic send_group(input logic known, input fp32_t sum, input logic gapped);
		for (int i = 0; i < NUM_INPUTS; i++) begin
			if (gapped && rand_below(4) == 0)
				idle_cycles(1 + rand_below(2));
			@(negedge clk);
			if (i == 0) begin
				known_valid = known;
				known_sum   = sum;
			end
			i_valid = 1'b1;
			i_data  = grp[i];
		end
	endtask

	initial begin
		seed        = LCG_SEED;
		rst_n       = 1'b0;
		i_valid     = 1'b0;
		i_data      = '0;
		known_valid = 1'b0;
		known_sum   = '0;
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		idle_cycles(2);

		foreach (grp[i]) grp[i] = '0;
		send_group(1'b1, 32'h00000000, 1'b0);
		idle_cycles(3);

		foreach (grp[i]) grp[i] = int_to_fp(i + 1);   // 1.0 .. 32.0
		send_group(1'b1, 32'h44040000, 1'b0);
		idle_cycles(3);

		// pairs of x and -x so every first-level adder cancels
		for (int k = 0; k < NUM_INPUTS / 2; k++) begin
			grp[2*k]     = random_float(100, 150);
			grp[2*k + 1] = grp[2*k] ^ 32'h80000000;
		end
		send_group(1'b1, 32'h00000000, 1'b0);
		idle_cycles(3);

		// 2^23 + 0.5 is a tie that rounds to even and the rest adds exactly
		grp[0] = 32'h4b000000;
		for (int i = 1; i < NUM_INPUTS; i++)
			grp[i] = 32'h3f000000;
		send_group(1'b1, 32'h4b00000f, 1'b0);
		idle_cycles(3);

		repeat (20) begin   // back to back with several groups in flight
			foreach (grp[i]) grp[i] = random_float(100, 150);
			send_group(1'b0, '0, 1'b0);
		end
		idle_cycles(3);

		repeat (8) begin
			foreach (grp[i]) grp[i] = random_float(100, 150);
			send_group(1'b0, '0, 1'b1);
			idle_cycles(rand_below(5));
		end
		idle_cycles(3);

		foreach (grp[i]) grp[i] = random_float(254, 254) & 32'h7fffffff;
		send_group(1'b1, 32'h7f800000, 1'b0);
		idle_cycles(3);

		// denormals sit next to the smallest normal so an unflushed one shows in the sum
		for (int k = 0; k < NUM_INPUTS / 2; k++) begin
			grp[2*k]     = 32'h00800000;
			grp[2*k + 1] = random_float(1, 254) & 32'h807fffff;
		end
		send_group(1'b1, 32'h02800000, 1'b0);
		idle_cycles(2);

		while (pending != 0)
			@(negedge clk);
		idle_cycles(10);   // room for a stray pulse

		if (checks != NUM_GROUPS)
			$display("expected %0d results but saw %0d", NUM_GROUPS, checks);
		$display("results checked: %0d of %0d, errors: %0d", checks, NUM_GROUPS, errors);
		if (errors == 0 && checks == NUM_GROUPS)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// ==== tb/fp_sum_checker.sv ====
module fp_sum_checker
	import fp_sum_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  logic  i_valid,
	input  fp32_t i_data,
	input  logic  i_sum_valid,
	input  fp32_t i_sum,
	input  logic  i_known_valid,
	input  fp32_t i_known_sum,
	output int    o_checks,
	output int    o_errors,
	output int    o_pending
);
	timeunit 1ns;
	timeprecision 1ps;

	fp32_t  words [NUM_INPUTS];
	int     fill;
	longint cycle;
	fp32_t  exp_q [$];
	longint due_q [$];   // sampled edge where o_valid is expected high

	// one binary32 add with flush to zero, nearest even and overflow to infinity
	function automatic fp32_t ref_add(input fp32_t a, input fp32_t b);
		int          ea;
		int          eb;
		int          e_big;
		int          e_small;
		int          d;
		int          p;
		int          sh;
		int          e;
		logic        s_big;
		logic        s_small;
		logic [63:0] m_big;
		logic [63:0] m_small;
		logic [63:0] lost;
		logic [63:0] r;
		logic [63:0] rem;
		logic [63:0] half;
		logic [63:0] mant;
		ea = int'(a[30:23]);
		eb = int'(b[30:23]);
		if (ea == 255)
			return {a[31], 8'hff, 23'h0};
		if (eb == 255)
			return {b[31], 8'hff, 23'h0};
		if (ea == 0 && eb == 0)
			return {a[31] & b[31], 31'h0};   // only -0 + -0 stays negative
		if (ea == 0)
			return b;
		if (eb == 0)
			return a;
		if (a[30:0] >= b[30:0]) begin
			s_big   = a[31];
			e_big   = ea;
			m_big   = {41'd1, a[22:0]};
			s_small = b[31];
			e_small = eb;
			m_small = {41'd1, b[22:0]};
		end else begin
			s_big   = b[31];
			e_big   = eb;
			m_big   = {41'd1, b[22:0]};
			s_small = a[31];
			e_small = ea;
			m_small = {41'd1, a[22:0]};
		end
		d = e_big - e_small;
		m_big = m_big << 30;   // 30 spare bits below the mantissa
		if (d > 40) begin
			m_small = 64'd1;
		end else begin
			m_small = m_small << 30;
			lost    = m_small & ((64'd1 << d) - 64'd1);
			m_small = (m_small >> d) | {63'd0, lost != 0};
		end
		r = (s_big == s_small) ? m_big + m_small : m_big - m_small;
		if (r == 0)
			return 32'h0;
		p = 0;
		for (int i = 0; i < 64; i++)
			if (r[i]) p = i;
		sh   = p - 23;
		mant = r >> sh;
		rem  = r & ((64'd1 << sh) - 64'd1);
		half = 64'd1 << (sh - 1);
		if (rem > half || (rem == half && mant[0]))
			mant = mant + 64'd1;
		e = e_big + p - 53;
		if (mant[24]) begin   // rounding carried into a new bit
			mant = mant >> 1;
			e    = e + 1;
		end
		if (e <= 0)
			return {s_big, 31'h0};
		if (e >= 255)
			return {s_big, 8'hff, 23'h0};
		return {s_big, e[7:0], mant[22:0]};
	endfunction

	// pairwise in tree order with 2k and 2k+1 at every level
	function automatic fp32_t group_sum(input fp32_t w [NUM_INPUTS]);
		fp32_t v [NUM_INPUTS];
		int    n;
		v = w;
		n = NUM_INPUTS;
		while (n > 1) begin
			for (int k = 0; k < n / 2; k++)
				v[k] = ref_add(v[2*k], v[2*k + 1]);
			n = n / 2;
		end
		return v[0];
	endfunction

	always @(posedge clk) begin : compare
		fp32_t  expected;
		longint due;
		if (!rst_n) begin
			fill = 0;
			cycle = 0;
			exp_q.delete();
			due_q.delete();
			o_checks  = 0;
			o_errors  = 0;
			o_pending = 0;
		end else begin
			cycle++;
			if (i_sum_valid) begin
				if (exp_q.size() == 0) begin
					o_errors++;
					$display("o_valid pulse at cycle %0d with no group pending", cycle);
				end else begin
					expected = exp_q.pop_front();
					due      = due_q.pop_front();
					o_checks++;
					if (cycle < due) begin
						o_errors++;
						$display("o_valid came %0d cycles early at cycle %0d", due - cycle, cycle);
					end else if (cycle > due) begin
						o_errors++;
						$display("o_valid came %0d cycles late at cycle %0d", cycle - due, cycle);
					end
					if (i_sum !== expected) begin
						o_errors++;
						$display("[FAIL] o_sum expected 0x%08h got 0x%08h", expected, i_sum);
					end
				end
			end
			if (exp_q.size() > 0 && due_q[0] < cycle) begin
				o_errors++;
				$display("no o_valid pulse for the group due at cycle %0d", due_q[0]);
				void'(exp_q.pop_front());
				void'(due_q.pop_front());
			end
			if (i_valid) begin
				words[fill] = i_data;
				fill++;
				if (fill == NUM_INPUTS) begin
					fill     = 0;
					expected = group_sum(words);
					if (i_known_valid && expected !== i_known_sum) begin
						o_errors++;
						$display("reference sum 0x%08h differs from the known group sum 0x%08h",
							expected, i_known_sum);
					end
					exp_q.push_back(expected);
					due_q.push_back(cycle + SUM_LATENCY + 1);
				end
			end
			o_pending = exp_q.size();
		end
	end

endmodule

// ==== src/fp_sum32.sv ====
module fp_sum32
	import fp_sum_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  logic  i_valid,
	input  fp32_t i_data,
	output logic  o_valid,
	output fp32_t o_sum
);

	operand_vec_t operands;
	logic         group_valid;   // full group ready, one cycle

	operand_collector i_collector (
		.clk           (clk),
		.rst_n         (rst_n),
		.i_valid       (i_valid),
		.i_data        (i_data),
		.o_operands    (operands),
		.o_group_valid (group_valid)
	);

	// sum appears SUM_LATENCY cycles after group_valid
	adder_tree i_tree (
		.clk           (clk),
		.rst_n         (rst_n),
		.i_group_valid (group_valid),
		.i_operands    (operands),
		.o_valid       (o_valid),
		.o_sum         (o_sum)
	);

endmodule

// ==== src/adder_tree.sv ====
module adder_tree
	import fp_sum_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,
	input  logic         i_group_valid,
	input  operand_vec_t i_operands,
	output logic         o_valid,
	output fp32_t        o_sum
);

	// node k < NUM_INPUTS is operand k, node NUM_INPUTS+j is the sum of adder j
	// adder j always adds nodes 2j and 2j+1, which fixes the summation order
	fp32_t                 node [2*NUM_INPUTS-1];
	logic [NUM_INPUTS-2:0] add_vld;

	for (genvar i = 0; i < NUM_INPUTS; i++) begin : g_leaf
		assign node[i] = i_operands[i];
	end

	for (genvar l = 0; l < TREE_LEVELS; l++) begin : g_level
		localparam int LANES    = NUM_INPUTS >> (l + 1);
		localparam int ADD_BASE = NUM_INPUTS - (NUM_INPUTS >> l);   // first adder of level

		logic lvl_in_vld;

		// lanes of a level run in lockstep, lane 0 stands for all
		if (l == 0) begin : g_first
			assign lvl_in_vld = i_group_valid;
		end else begin : g_next
			assign lvl_in_vld = add_vld[NUM_INPUTS - (NUM_INPUTS >> (l - 1))];
		end

		for (genvar k = 0; k < LANES; k++) begin : g_lane
			fp32_adder i_add (
				.clk     (clk),
				.rst_n   (rst_n),
				.i_valid (lvl_in_vld),
				.i_a     (node[2*(ADD_BASE + k)]),
				.i_b     (node[2*(ADD_BASE + k) + 1]),
				.o_valid (add_vld[ADD_BASE + k]),
				.o_sum   (node[NUM_INPUTS + ADD_BASE + k])
			);
		end
	end

	assign o_sum   = node[2*NUM_INPUTS-2];   // root of the tree
	assign o_valid = add_vld[NUM_INPUTS-2];

endmodule

// ==== src/operand_collector.sv ====
module operand_collector
	import fp_sum_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,
	input  logic         i_valid,
	input  fp32_t        i_data,
	output operand_vec_t o_operands,
	output logic         o_group_valid
);

	logic [CNT_W-1:0] wr_cnt;   // next slot to fill
	logic             last_slot;

	assign last_slot = (wr_cnt == CNT_W'(NUM_INPUTS - 1));

	// counter wraps on its own after the last slot
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_cnt        <= '0;
			o_group_valid <= 1'b0;
		end else begin
			o_group_valid <= i_valid && last_slot;   // one cycle, buffer is full
			if (i_valid)
				wr_cnt <= wr_cnt + CNT_W'(1);
		end
	end

	// the tree samples the buffer on the same edge a new word may land in
	// slot 0, so it still sees the completed group
	always_ff @(posedge clk) begin
		if (i_valid)
			o_operands[wr_cnt] <= i_data;
	end

endmodule

// ==== src/fp32_adder.sv ====
module fp32_adder
	import fp_sum_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  logic  i_valid,
	input  fp32_t i_a,
	input  fp32_t i_b,
	output logic  o_valid,
	output fp32_t o_sum
);

	logic [ADD_LATENCY-1:0] vld_pipe;

	// stage 1: unpack, flush, order by magnitude
	logic [EXP_W-1:0]  a_exp;
	logic [EXP_W-1:0]  b_exp;
	logic [MANT_W-1:0] a_man;
	logic [MANT_W-1:0] b_man;
	logic              a_big;

	logic              s1_sign;
	logic              s1_sub;
	logic              s1_both_neg;
	logic [EXP_W-1:0]  s1_exp;
	logic [EXP_W-1:0]  s1_diff;
	logic [MANT_W-1:0] s1_man_big;
	logic [MANT_W-1:0] s1_man_small;

	always_comb begin
		a_exp = i_a[EXP_LSB +: EXP_W];
		b_exp = i_b[EXP_LSB +: EXP_W];
		// exponent zero covers zero and denormals, both become zero
		a_man = (a_exp == '0) ? '0 : {1'b1, i_a[MAN_W-1:0]};
		b_man = (b_exp == '0) ? '0 : {1'b1, i_b[MAN_W-1:0]};
		a_big = {a_exp, a_man} >= {b_exp, b_man};
	end

	always_ff @(posedge clk) begin
		s1_sub      <= i_a[SIGN_BIT] ^ i_b[SIGN_BIT];
		s1_both_neg <= i_a[SIGN_BIT] & i_b[SIGN_BIT];   // -0 + -0 keeps its sign
		if (a_big) begin
			s1_sign      <= i_a[SIGN_BIT];
			s1_exp       <= a_exp;
			s1_diff      <= a_exp - b_exp;
			s1_man_big   <= a_man;
			s1_man_small <= b_man;
		end else begin
			s1_sign      <= i_b[SIGN_BIT];
			s1_exp       <= b_exp;
			s1_diff      <= b_exp - a_exp;
			s1_man_big   <= b_man;
			s1_man_small <= a_man;
		end
	end

	// stage 2: align the smaller operand
	logic [ALIGN_W-1:0] small_ext;
	logic [ALIGN_W-1:0] lost_mask;
	logic [ALIGN_W-1:0] aligned;
	logic               sticky;

	logic               s2_sign;
	logic               s2_sub;
	logic               s2_both_neg;
	logic [EXP_W-1:0]   s2_exp;
	logic [ALIGN_W-1:0] s2_big;
	logic [ALIGN_W-1:0] s2_small;

	always_comb begin
		small_ext = {s1_man_small, 3'b000};
		if (s1_diff >= ALIGN_W) begin
			lost_mask = '1;   // everything shifts out
			sticky    = |s1_man_small;
			aligned   = ALIGN_W'(sticky);
		end else begin
			lost_mask = (ALIGN_W'(1) << s1_diff) - ALIGN_W'(1);
			sticky    = |(small_ext & lost_mask);
			aligned   = (small_ext >> s1_diff) | ALIGN_W'(sticky);
		end
	end

	always_ff @(posedge clk) begin
		s2_sign     <= s1_sign;
		s2_sub      <= s1_sub;
		s2_both_neg <= s1_both_neg;
		s2_exp      <= s1_exp;
		s2_big      <= {s1_man_big, 3'b000};
		s2_small    <= aligned;
	end

	// stage 3: add or subtract, big >= small so no sign flip
	logic               s3_sign;
	logic               s3_both_neg;
	logic [EXP_W-1:0]   s3_exp;
	logic [ALIGN_W:0]   s3_mant;   // top bit is the carry

	always_ff @(posedge clk) begin
		s3_sign     <= s2_sign;
		s3_both_neg <= s2_both_neg;
		s3_exp      <= s2_exp;
		if (s2_sub)
			s3_mant <= {1'b0, s2_big} - {1'b0, s2_small};
		else
			s3_mant <= {1'b0, s2_big} + {1'b0, s2_small};
	end

	// stage 4: leading zero count
	function automatic logic [LZ_W-1:0] count_lz(input logic [ALIGN_W:0] v);
		logic [LZ_W-1:0] n;
		n = LZ_W'(ALIGN_W + 1);   // all zero
		for (int i = 0; i <= ALIGN_W; i++) begin
			if (v[i])
				n = LZ_W'(ALIGN_W - i);   // highest set bit wins
		end
		return n;
	endfunction

	logic               s4_sign;
	logic               s4_zero;
	logic [EXP_W-1:0]   s4_exp;
	logic [ALIGN_W:0]   s4_mant;
	logic [LZ_W-1:0]    s4_lz;

	always_ff @(posedge clk) begin
		s4_zero <= (s3_mant == '0);
		// exact cancellation gives +0 unless both inputs were negative
		s4_sign <= (s3_mant == '0) ? s3_both_neg : s3_sign;
		s4_exp  <= s3_exp;
		s4_mant <= s3_mant;
		s4_lz   <= count_lz(s3_mant);
	end

	// stage 5: normalize so the hidden bit lands on ALIGN_W-1
	logic [ALIGN_W:0]          shl;
	logic [ALIGN_W-1:0]        norm;

	logic                      s5_sign;
	logic                      s5_zero;
	logic signed [EXP_EXT_W-1:0] s5_exp;
	logic [ALIGN_W-1:0]        s5_norm;

	always_comb begin
		shl = s4_mant << (s4_lz - LZ_W'(1));
		if (s4_lz == '0)
			norm = {s4_mant[ALIGN_W:2], s4_mant[1] | s4_mant[0]};   // carry out, shift right
		else
			norm = shl[ALIGN_W-1:0];
	end

	always_ff @(posedge clk) begin
		s5_sign <= s4_sign;
		s5_zero <= s4_zero;
		s5_exp  <= $signed({2'b00, s4_exp}) + EXP_EXT_W'(1) - $signed(EXP_EXT_W'(s4_lz));
		s5_norm <= norm;
	end

	// stage 6: round to nearest even
	logic              round_up;
	logic [MANT_W:0]   rounded;

	logic                      s6_sign;
	logic                      s6_zero;
	logic signed [EXP_EXT_W-1:0] s6_exp;
	logic [MAN_W-1:0]          s6_man;

	always_comb begin
		round_up = s5_norm[2] & (s5_norm[1] | s5_norm[0] | s5_norm[3]);
		rounded  = {1'b0, s5_norm[ALIGN_W-1:3]} + (MANT_W + 1)'(round_up);
	end

	always_ff @(posedge clk) begin
		s6_sign <= s5_sign;
		s6_zero <= s5_zero;
		s6_exp  <= s5_exp + EXP_EXT_W'(rounded[MANT_W]);   // mantissa rolled over
		s6_man  <= rounded[MAN_W-1:0];
	end

	// stage 7: pack with overflow and underflow handling
	always_ff @(posedge clk) begin
		if (s6_zero || s6_exp <= 0)
			o_sum <= {s6_sign, {(FP_W-1){1'b0}}};
		else if (s6_exp >= EXP_MAX)
			o_sum <= {s6_sign, {EXP_W{1'b1}}, {MAN_W{1'b0}}};
		else
			o_sum <= {s6_sign, s6_exp[EXP_W-1:0], s6_man};
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			vld_pipe <= '0;
		else
			vld_pipe <= {vld_pipe[ADD_LATENCY-2:0], i_valid};
	end

	assign o_valid = vld_pipe[ADD_LATENCY-1];

endmodule

// ==== src/fp_sum_pkg.sv ====
package fp_sum_pkg;

	// binary32 format
	localparam int FP_W     = 32;
	localparam int EXP_W    = 8;
	localparam int MAN_W    = 23;
	localparam int EXP_BIAS = 127;

	// field positions inside a word
	localparam int SIGN_BIT = FP_W - 1;
	localparam int EXP_LSB  = MAN_W;
	localparam int EXP_MAX  = (1 << EXP_W) - 1;   // all-ones exponent, infinity

	// adder datapath widths
	localparam int MANT_W    = MAN_W + 1;          // with hidden bit
	localparam int ALIGN_W   = MANT_W + 3;         // plus guard, round, sticky
	localparam int LZ_W      = $clog2(ALIGN_W + 2); // holds counts up to ALIGN_W + 1
	localparam int EXP_EXT_W = EXP_W + 2;          // signed, room for under/overflow

	// group and tree geometry
	localparam int NUM_INPUTS  = 32;
	localparam int TREE_LEVELS = $clog2(NUM_INPUTS);
	localparam int CNT_W       = $clog2(NUM_INPUTS);

	// latencies in clock cycles
	localparam int ADD_LATENCY = 7;
	localparam int SUM_LATENCY = TREE_LEVELS * ADD_LATENCY;

	typedef logic [FP_W-1:0] fp32_t;

	// one full group, word k sits at index k
	typedef logic [NUM_INPUTS-1:0][FP_W-1:0] operand_vec_t;

endpackage
